// File: src/cdi_pkg.sv
`default_nettype none

package cdi_pkg;

    // ==============================
    // Widths
    // ==============================

    localparam int IOCTL_ADDR_BITS  = 25;
    localparam int IOCTL_WORD_BITS  = 16;
    localparam int IOCTL_INDEX_BITS = 16;
    localparam int SDRAM_ADDR_BITS  = 25;
    localparam int SDRAM_WORD_BITS  = 16;
    localparam int WORM_ADDR_BITS   = 13;
    localparam int WORM_BYTE_BITS   = 8;

    typedef logic [IOCTL_ADDR_BITS-1:0]  ioctl_addr_t;
    typedef logic [IOCTL_WORD_BITS-1:0]  ioctl_word_t;
    typedef logic [IOCTL_INDEX_BITS-1:0] ioctl_index_t;
    typedef logic [SDRAM_ADDR_BITS-1:0]  sdram_addr_t;
    typedef logic [SDRAM_WORD_BITS-1:0]  sdram_word_t;
    typedef logic [WORM_ADDR_BITS-1:0]   worm_addr_t;
    typedef logic [WORM_BYTE_BITS-1:0]   worm_byte_t;

    // ==============================
    // Download mapping
    // ==============================

    // Index bit 6 set means the image goes to the slave WORM
    localparam int WORM_INDEX_BIT = 6;

    // Boot ROM sits where the top three SDRAM address bits are 001
    localparam sdram_addr_t ROM_REGION_BASE = 25'h040_0000;
    localparam int          ROM_OFFSET_BITS = 22;

    // Request FIFO sizing
    localparam int REQ_FIFO_DEPTH = 4;
    localparam int REQ_PTR_BITS   = $clog2(REQ_FIFO_DEPTH);
    localparam int REQ_CNT_BITS   = $clog2(REQ_FIFO_DEPTH + 1);

    // ==============================
    // Transfer records
    // ==============================

    // One word write into the ROM region
    typedef struct packed {
        sdram_addr_t addr;
        sdram_word_t data;
    } sdram_req_t;

    // One byte write into the WORM
    typedef struct packed {
        worm_addr_t adr;
        worm_byte_t data;
    } worm_wr_t;

    // Who currently owns the SDRAM controller port
    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_ROM_WRITE,
        OWN_REFRESH
    } port_owner_t;

endpackage

`default_nettype wire

// File: src/ioctl_router.sv
`default_nettype none

module ioctl_router (
    input  logic                  clk_sys,
    input  logic                  cditop_reset,
    input  logic                  ioctl_wr,
    input  cdi_pkg::ioctl_index_t ioctl_index,
    input  cdi_pkg::ioctl_addr_t  ioctl_addr,
    input  cdi_pkg::ioctl_word_t  ioctl_dout,
    input  logic                  req_ready,
    output logic                  ioctl_wait,
    output logic                  req_valid,
    output cdi_pkg::sdram_req_t   req,
    output logic                  slave_worm_wr,
    output cdi_pkg::worm_wr_t     worm
);

    logic                 accept;
    logic                 to_worm;
    logic                 hi_pending;
    cdi_pkg::worm_byte_t  hi_byte;
    cdi_pkg::sdram_addr_t rom_offset;

    assign to_worm = ioctl_index[cdi_pkg::WORM_INDEX_BIT];

    // Stall the source while the high byte goes out or the request is stuck
    assign ioctl_wait = hi_pending || (req_valid && !req_ready);
    assign accept     = ioctl_wr && !ioctl_wait;

    // Word aligned offset inside the ROM region
    assign rom_offset = cdi_pkg::sdram_addr_t'(
        {ioctl_addr[cdi_pkg::ROM_OFFSET_BITS-1:1], 1'b0});

    // ==============================
    // Boot ROM requests
    // ==============================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            req_valid <= 1'b0;
        end else if (accept && !to_worm) begin
            req_valid <= 1'b1;
        end else if (req_ready) begin
            req_valid <= 1'b0;
        end
    end

    // Download is little endian, the 68k wants big endian
    always_ff @(posedge clk_sys) begin
        if (accept && !to_worm) begin
            req.addr <= cdi_pkg::ROM_REGION_BASE + rom_offset;
            req.data <= {ioctl_dout[7:0], ioctl_dout[15:8]};
        end
    end

    // ==============================
    // WORM byte writes
    // ==============================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            hi_pending    <= 1'b0;
            slave_worm_wr <= 1'b0;
        end else begin
            hi_pending    <= accept && to_worm;
            slave_worm_wr <= (accept && to_worm) || hi_pending;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept && to_worm) begin
            // Lower byte goes first
            worm.adr  <= ioctl_addr[cdi_pkg::WORM_ADDR_BITS-1:0];
            worm.data <= ioctl_dout[7:0];
            hi_byte   <= ioctl_dout[15:8];
        end else if (hi_pending) begin
            worm.adr[0] <= 1'b1;
            worm.data   <= hi_byte;
        end
    end

    // A stalled request must not change under the FIFO
    assert property (@(posedge clk_sys) disable iff (cditop_reset)
        req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

`default_nettype wire

// File: src/sdram_req_fifo.sv
`default_nettype none

module sdram_req_fifo (
    input  logic                clk_sys,
    input  logic                cditop_reset,
    input  logic                in_valid,
    input  cdi_pkg::sdram_req_t in_req,
    input  logic                out_ready,
    output logic                in_ready,
    output logic                out_valid,
    output cdi_pkg::sdram_req_t out_req,
    output logic                empty
);

    cdi_pkg::sdram_req_t             mem [cdi_pkg::REQ_FIFO_DEPTH];
    logic [cdi_pkg::REQ_PTR_BITS-1:0] wr_ptr;
    logic [cdi_pkg::REQ_PTR_BITS-1:0] rd_ptr;
    logic [cdi_pkg::REQ_CNT_BITS-1:0] count;
    logic                            push;
    logic                            pop;

    assign empty     = (count == '0);
    assign in_ready  = (count != cdi_pkg::REQ_CNT_BITS'(cdi_pkg::REQ_FIFO_DEPTH));
    assign out_valid = !empty;
    assign out_req   = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk_sys) begin
        if (push) begin
            mem[wr_ptr] <= in_req;
        end
    end

    // Pointers wrap by themselves since the depth is a power of two
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk_sys) disable iff (cditop_reset)
        count <= cdi_pkg::REQ_CNT_BITS'(cdi_pkg::REQ_FIFO_DEPTH));

endmodule

`default_nettype wire

// File: src/sdram_port_arbiter.sv
`default_nettype none

module sdram_port_arbiter (
    input  logic                 clk_sys,
    input  logic                 cditop_reset,
    input  logic                 ioctl_download,
    input  logic                 fifo_valid,
    input  cdi_pkg::sdram_req_t  fifo_req,
    input  logic                 sdram_busy,
    output logic                 fifo_ready,
    output cdi_pkg::sdram_addr_t sdram_addr,
    output cdi_pkg::sdram_word_t sdram_din,
    output logic                 sdram_wr,
    output logic                 sdram_refresh
);

    cdi_pkg::port_owner_t owner;
    logic                 busy_seen;
    logic                 cmd_done;

    // Only take a request when a write can go out right away
    assign fifo_ready = (owner == cdi_pkg::OWN_IDLE) && !sdram_busy;

    // Command finished once busy has come and gone again
    assign cmd_done = busy_seen && !sdram_busy;

    // ==============================
    // Owner FSM
    // ==============================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            owner         <= cdi_pkg::OWN_IDLE;
            busy_seen     <= 1'b0;
            sdram_wr      <= 1'b0;
            sdram_refresh <= 1'b0;
        end else begin
            sdram_wr      <= 1'b0;
            sdram_refresh <= 1'b0;

            case (owner)
                cdi_pkg::OWN_IDLE: begin
                    busy_seen <= 1'b0;
                    // ROM writes first, refresh only during download
                    if (!sdram_busy) begin
                        if (fifo_valid) begin
                            sdram_wr <= 1'b1;
                            owner    <= cdi_pkg::OWN_ROM_WRITE;
                        end else if (ioctl_download) begin
                            sdram_refresh <= 1'b1;
                            owner         <= cdi_pkg::OWN_REFRESH;
                        end
                    end
                end
                cdi_pkg::OWN_ROM_WRITE, cdi_pkg::OWN_REFRESH: begin
                    if (sdram_busy) begin
                        busy_seen <= 1'b1;
                    end
                    if (cmd_done) begin
                        owner <= cdi_pkg::OWN_IDLE;
                    end
                end
                default: owner <= cdi_pkg::OWN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (fifo_valid && fifo_ready) begin
            sdram_addr <= fifo_req.addr;
            sdram_din  <= fifo_req.data;
        end
    end

    assert property (@(posedge clk_sys) disable iff (cditop_reset)
        !(sdram_wr && sdram_refresh));

    // Controller must be idle whenever a command strobe is seen
    assert property (@(posedge clk_sys) disable iff (cditop_reset)
        (sdram_wr || sdram_refresh) |-> !sdram_busy);

endmodule

`default_nettype wire

// File: src/cdi_boot_loader.sv
`default_nettype none

module cdi_boot_loader (
    input  logic                  clk_sys,
    input  logic                  cditop_reset,
    input  logic                  ioctl_download,
    input  logic                  ioctl_wr,
    input  cdi_pkg::ioctl_index_t ioctl_index,
    input  cdi_pkg::ioctl_addr_t  ioctl_addr,
    input  cdi_pkg::ioctl_word_t  ioctl_dout,
    input  logic                  sdram_busy,
    output logic                  ioctl_wait,
    output cdi_pkg::sdram_addr_t  sdram_addr,
    output cdi_pkg::sdram_word_t  sdram_din,
    output logic                  sdram_wr,
    output logic                  sdram_refresh,
    output cdi_pkg::worm_addr_t   slave_worm_adr,
    output cdi_pkg::worm_byte_t   slave_worm_data,
    output logic                  slave_worm_wr
);

    logic                req_valid;
    logic                req_ready;
    cdi_pkg::sdram_req_t req;
    logic                fifo_valid;
    logic                fifo_ready;
    cdi_pkg::sdram_req_t fifo_req;
    cdi_pkg::worm_wr_t   worm;

    ioctl_router u_router (
        .clk_sys       (clk_sys),
        .cditop_reset  (cditop_reset),
        .ioctl_wr      (ioctl_wr),
        .ioctl_index   (ioctl_index),
        .ioctl_addr    (ioctl_addr),
        .ioctl_dout    (ioctl_dout),
        .req_ready     (req_ready),
        .ioctl_wait    (ioctl_wait),
        .req_valid     (req_valid),
        .req           (req),
        .slave_worm_wr (slave_worm_wr),
        .worm          (worm)
    );

    sdram_req_fifo u_fifo (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .in_valid     (req_valid),
        .in_req       (req),
        .out_ready    (fifo_ready),
        .in_ready     (req_ready),
        .out_valid    (fifo_valid),
        .out_req      (fifo_req),
        .empty        ()
    );

    sdram_port_arbiter u_arbiter (
        .clk_sys        (clk_sys),
        .cditop_reset   (cditop_reset),
        .ioctl_download (ioctl_download),
        .fifo_valid     (fifo_valid),
        .fifo_req       (fifo_req),
        .sdram_busy     (sdram_busy),
        .fifo_ready     (fifo_ready),
        .sdram_addr     (sdram_addr),
        .sdram_din      (sdram_din),
        .sdram_wr       (sdram_wr),
        .sdram_refresh  (sdram_refresh)
    );

    // WORM port of the slave
    assign slave_worm_adr  = worm.adr;
    assign slave_worm_data = worm.data;

endmodule

`default_nettype wire

// File: sim/tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

cdi_pkg::sdram_req_t exp_rom_q[$];
cdi_pkg::worm_wr_t   exp_worm_q[$];

// ==============================
// Expected values and compares
// ==============================

// Byte swapped word at the even offset inside the ROM region
function automatic cdi_pkg::sdram_req_t rom_expect(input cdi_pkg::ioctl_addr_t a,
                                                   input cdi_pkg::ioctl_word_t d);
    cdi_pkg::sdram_req_t r;
    r.addr = cdi_pkg::ROM_REGION_BASE
           | (a & cdi_pkg::sdram_addr_t'((1 << cdi_pkg::ROM_OFFSET_BITS) - 2));
    r.data = {d[7:0], d[15:8]};
    return r;
endfunction

function automatic cdi_pkg::worm_wr_t worm_expect(input cdi_pkg::ioctl_addr_t a,
                                                  input cdi_pkg::worm_byte_t b,
                                                  input logic high);
    cdi_pkg::worm_wr_t w;
    w.adr  = a[12:0] | cdi_pkg::worm_addr_t'(high);
    w.data = b;
    return w;
endfunction

task automatic check_req(input string name, input cdi_pkg::sdram_req_t got,
                         input cdi_pkg::sdram_req_t exp);
    if (got !== exp) begin
        value_errs++;
        $display("[ERROR] %0t %s got %h/%h expected %h/%h", $time, name,
                 got.addr, got.data, exp.addr, exp.data);
    end
endtask

task automatic compare_worm(input string name, input cdi_pkg::worm_wr_t got,
                            input cdi_pkg::worm_wr_t exp);
    if (got !== exp) begin
        value_errs++;
        $display("[ERROR] %0t %s got %h/%h expected %h/%h", $time, name,
                 got.adr, got.data, exp.adr, exp.data);
    end
endtask

task automatic verify_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        value_errs++;
        $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic report_failure(input string msg);
    other_errs++;
    $display("Failure at %0t: %s", $time, msg);
endtask

// ==============================
// Stimulus and waits
// ==============================

// Holds the word until an edge with ioctl_wait low takes it
task automatic send_word(input cdi_pkg::ioctl_index_t idx, input cdi_pkg::ioctl_addr_t a,
                         input cdi_pkg::ioctl_word_t d);
    int   cycles;
    int   cyc_seen;
    logic stalled;
    ioctl_wr    <= 1'b1;
    ioctl_index <= idx;
    ioctl_addr  <= a;
    ioctl_dout  <= d;
    cycles   = 0;
    cyc_seen = 0;
    stalled  = 1'b1;
    while (stalled && cycles < WAIT_LIMIT) begin
        @(negedge clk_sys);
        stalled  = ioctl_wait;
        cyc_seen = cycle_cnt;
        @(posedge clk_sys);
        cycles++;
    end
    if (stalled) begin
        report_failure("download word was never accepted");
    end else begin
        accept_cyc = cyc_seen + 1;
    end
endtask

task automatic download_word(input cdi_pkg::ioctl_index_t idx, input cdi_pkg::ioctl_addr_t a,
                             input cdi_pkg::ioctl_word_t d);
    if (idx[6]) begin
        exp_worm_q.push_back(worm_expect(a, d[7:0], 1'b0));
        exp_worm_q.push_back(worm_expect(a, d[15:8], 1'b1));
    end else begin
        exp_rom_q.push_back(rom_expect(a, d));
    end
    send_word(idx, a, d);
endtask

task automatic wait_for_logs(input int rom_n, input int worm_n);
    int cycles;
    cycles = 0;
    while ((rom_log.size() < rom_n || worm_log.size() < worm_n) && cycles < WAIT_LIMIT) begin
        @(posedge clk_sys);
        cycles++;
    end
    if (rom_log.size() < rom_n || worm_log.size() < worm_n) begin
        report_failure($sformatf("timed out waiting for %0d ROM and %0d WORM writes",
                                 rom_n, worm_n));
    end
endtask

// Four idle cycles in a row cover the router to arbiter pipeline
task automatic settle_quiet();
    int cycles;
    int quiet;
    cycles = 0;
    quiet  = 0;
    while (quiet < 4 && cycles < WAIT_LIMIT) begin
        @(negedge clk_sys);
        if (sdram_busy || sdram_wr || sdram_refresh || slave_worm_wr) begin
            quiet = 0;
        end else begin
            quiet++;
        end
        @(posedge clk_sys);
        cycles++;
    end
    if (quiet < 4) begin
        report_failure("SDRAM and WORM ports never went idle");
    end
endtask

task automatic drain_and_compare(input int rom_base, input int worm_base);
    int rom_seen;
    int worm_seen;
    ioctl_wr       <= 1'b0;
    ioctl_download <= 1'b0;
    wait_for_logs(rom_base + exp_rom_q.size(), worm_base + exp_worm_q.size());
    settle_quiet();
    rom_seen  = rom_log.size() - rom_base;
    worm_seen = worm_log.size() - worm_base;
    if (rom_seen != exp_rom_q.size()) begin
        report_failure($sformatf("%0d ROM writes seen, %0d expected", rom_seen, exp_rom_q.size()));
    end
    if (worm_seen != exp_worm_q.size()) begin
        report_failure($sformatf("%0d WORM writes seen, %0d expected", worm_seen,
                                 exp_worm_q.size()));
    end
    for (int i = 0; i < exp_rom_q.size() && i < rom_seen; i++) begin
        check_req($sformatf("sdram_addr/sdram_din write %0d", i), rom_log[rom_base + i],
                  exp_rom_q[i]);
    end
    for (int i = 0; i < exp_worm_q.size() && i < worm_seen; i++) begin
        compare_worm($sformatf("slave_worm_adr/slave_worm_data write %0d", i),
                     worm_log[worm_base + i], exp_worm_q[i]);
    end
    exp_rom_q.delete();
    exp_worm_q.delete();
endtask

task automatic outputs_idle();
    verify_level("sdram_wr", sdram_wr, 1'b0);
    verify_level("sdram_refresh", sdram_refresh, 1'b0);
    verify_level("slave_worm_wr", slave_worm_wr, 1'b0);
    verify_level("ioctl_wait", ioctl_wait, 1'b0);
endtask

// ==============================
// Directed tests
// ==============================

task automatic single_rom_word();
    int rom_base;
    int worm_base;
    rom_base  = rom_log.size();
    worm_base = worm_log.size();
    busy_len       <= 3;
    ioctl_download <= 1'b1;
    download_word(16'h0000, 25'h1F2_3457, 16'hA1B2);
    drain_and_compare(rom_base, worm_base);
endtask

task automatic worm_word_split();
    int rom_base;
    int worm_base;
    rom_base  = rom_log.size();
    worm_base = worm_log.size();
    ioctl_download <= 1'b1;
    download_word(16'h0040, 25'h000_1A2C, 16'h5AC3);
    drain_and_compare(rom_base, worm_base);
    // Low byte right after the accepting edge, high byte one cycle later
    if (worm_log.size() >= worm_base + 2) begin
        if (worm_cyc[worm_base] != accept_cyc || worm_cyc[worm_base + 1] != accept_cyc + 1) begin
            report_failure("WORM strobes not in the two cycles after the word was taken");
        end
    end
endtask

task automatic rom_stream_backpressure();
    int rom_base;
    int worm_base;
    int wait_base;
    rom_base  = rom_log.size();
    worm_base = worm_log.size();
    wait_base = wait_cnt;
    busy_len       <= 6;
    ioctl_download <= 1'b1;
    for (int i = 0; i < 12; i++) begin
        download_word(16'h0000, cdi_pkg::ioctl_addr_t'(25'h000_0100 + 2 * i),
                      cdi_pkg::ioctl_word_t'(16'h1000 + 16'h0111 * i));
    end
    drain_and_compare(rom_base, worm_base);
    if (wait_cnt == wait_base) begin
        report_failure("ioctl_wait never rose during the long busy stream");
    end
endtask

task automatic mixed_index_stream();
    int rom_base;
    int worm_base;
    rom_base  = rom_log.size();
    worm_base = worm_log.size();
    busy_len       <= 0;
    ioctl_download <= 1'b1;
    for (int i = 0; i < 20; i++) begin
        download_word(cdi_pkg::ioctl_index_t'($urandom), cdi_pkg::ioctl_addr_t'($urandom),
                      cdi_pkg::ioctl_word_t'($urandom));
    end
    drain_and_compare(rom_base, worm_base);
endtask

task automatic refresh_and_reset();
    int start;
    int cycles;
    busy_len       <= 2;
    ioctl_download <= 1'b1;
    start  = refresh_cnt;
    cycles = 0;
    while (refresh_cnt < start + 4 && cycles < WAIT_LIMIT) begin
        @(posedge clk_sys);
        cycles++;
    end
    if (refresh_cnt < start + 4) begin
        report_failure("too few refresh pulses while ioctl_download was high");
    end
    ioctl_download <= 1'b0;
    settle_quiet();
    start = refresh_cnt;
    repeat (20) @(posedge clk_sys);
    if (refresh_cnt != start) begin
        report_failure("refresh issued while ioctl_download was low");
    end

    // Reset hits with ROM requests queued and the high WORM byte still pending
    busy_len       <= 6;
    ioctl_download <= 1'b1;
    for (int i = 0; i < 3; i++) begin
        send_word(16'h0000, cdi_pkg::ioctl_addr_t'(25'h000_0200 + 2 * i), 16'h1234);
    end
    send_word(16'h0040, 25'h000_0010, 16'hBEEF);
    ioctl_wr     <= 1'b0;
    cditop_reset <= 1'b1;
    @(posedge clk_sys);
    @(negedge clk_sys);
    outputs_idle();
    @(posedge clk_sys);
    cditop_reset   <= 1'b0;
    ioctl_download <= 1'b0;
    // First edge with reset low, queued requests must be gone
    @(posedge clk_sys);
    @(negedge clk_sys);
    outputs_idle();
    @(posedge clk_sys);
endtask

`endif

// File: sim/tb_cdi_boot_loader.sv
`default_nettype none

module tb_cdi_boot_loader;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 400;

    logic                  clk_sys;
    logic                  cditop_reset;
    logic                  ioctl_download;
    logic                  ioctl_wr;
    cdi_pkg::ioctl_index_t ioctl_index;
    cdi_pkg::ioctl_addr_t  ioctl_addr;
    cdi_pkg::ioctl_word_t  ioctl_dout;
    logic                  sdram_busy = 1'b0;
    logic                  ioctl_wait;
    cdi_pkg::sdram_addr_t  sdram_addr;
    cdi_pkg::sdram_word_t  sdram_din;
    logic                  sdram_wr;
    logic                  sdram_refresh;
    cdi_pkg::worm_addr_t   slave_worm_adr;
    cdi_pkg::worm_byte_t   slave_worm_data;
    logic                  slave_worm_wr;

    // Busy cycles per SDRAM command, 0 picks 1 to 6 at random
    int busy_len;
    int busy_cnt  = 0;
    int cycle_cnt = 0;

    cdi_pkg::sdram_req_t rom_log[$];
    cdi_pkg::worm_wr_t   worm_log[$];
    int                  worm_cyc[$];
    int                  refresh_cnt = 0;
    int                  wait_cnt    = 0;
    int                  busy_errs   = 0;
    int                  value_errs  = 0;
    int                  other_errs  = 0;
    int                  accept_cyc  = 0;

    cdi_boot_loader u_dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ==============================
    // SDRAM controller model
    // ==============================

    // Busy rises the cycle after a command and stays up busy_cnt cycles
    always @(posedge clk_sys) begin
        if (cditop_reset) begin
            sdram_busy <= 1'b0;
            busy_cnt   <= 0;
        end else if (sdram_wr || sdram_refresh) begin
            sdram_busy <= 1'b1;
            busy_cnt   <= (busy_len == 0) ? int'($urandom_range(6, 1)) : busy_len;
        end else if (busy_cnt > 1) begin
            busy_cnt <= busy_cnt - 1;
        end else begin
            busy_cnt   <= 0;
            sdram_busy <= 1'b0;
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk_sys) begin
        if (sdram_wr) begin
            rom_log.push_back('{addr: sdram_addr, data: sdram_din});
        end
        if (slave_worm_wr) begin
            worm_log.push_back('{adr: slave_worm_adr, data: slave_worm_data});
            worm_cyc.push_back(cycle_cnt);
        end
        if (sdram_refresh) begin
            refresh_cnt++;
        end
        if (ioctl_wait) begin
            wait_cnt++;
        end
        if ((sdram_wr || sdram_refresh) && sdram_busy) begin
            busy_errs++;
            $display("Failure at %0t: SDRAM command issued while sdram_busy was high", $time);
        end
    end

    `include "tb_tests.svh"

    initial begin
        void'($urandom(32'hb809e3b6));
        cditop_reset   <= 1'b1;
        ioctl_download <= 1'b0;
        ioctl_wr       <= 1'b0;
        ioctl_index    <= '0;
        ioctl_addr     <= '0;
        ioctl_dout     <= '0;
        busy_len       <= 2;
        repeat (2) @(posedge clk_sys);
        cditop_reset <= 1'b0;
        @(posedge clk_sys);

        single_rom_word();
        worm_word_split();
        rom_stream_backpressure();
        mixed_index_stream();
        refresh_and_reset();

        $display("Errors: %0d value, %0d other, %0d busy", value_errs, other_errs, busy_errs);
        if (value_errs == 0 && other_errs == 0 && busy_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+sim
src/cdi_pkg.sv
src/ioctl_router.sv
src/sdram_req_fifo.sv
src/sdram_port_arbiter.sv
src/cdi_boot_loader.sv
sim/tb_cdi_boot_loader.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_cdi_boot_loader --Mdir obj_dir -o tb_cdi_boot_loader \
    || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/tb_cdi_boot_loader)"
echo "${sim_out}"
grep -qx "=== PASS ===" <<< "${sim_out}" && exit 0 || exit 1
